/* source/mem_pkg.sv */
`default_nettype none

package mem_pkg;

	localparam int reg_w         = 32;
	localparam int ram_addr_bits = 8;    // 256 words, byte address bits [9:2]

	// memory opcodes as resolved by execute
	typedef enum logic [3:0] {
		op_nop,
		op_lb,
		op_lbu,
		op_lh,
		op_lhu,
		op_lw,
		op_lwl,
		op_lwr,
		op_sb,
		op_sh,
		op_sw,
		op_swl,
		op_swr
	} mem_op_e;

	// final exception code, same numbering as Cause.ExcCode
	typedef enum logic [4:0] {
		exc_none  = 5'd0,
		exc_mod   = 5'd1,
		exc_tlbl  = 5'd2,
		exc_tlbs  = 5'd3,
		exc_adel  = 5'd4,
		exc_ades  = 5'd5,
		exc_sys   = 5'd8,
		exc_ri    = 5'd10,
		exc_cpu   = 5'd11,
		exc_eret  = 5'd14,
		exc_int   = 5'd15,
		exc_watch = 5'd23
	} exc_code_e;

	// flag positions in the raw except_i vector
	localparam int exc_bit_mod   = 1;
	localparam int exc_bit_tlbl  = 2;
	localparam int exc_bit_tlbs  = 3;
	localparam int exc_bit_adel  = 4;
	localparam int exc_bit_ades  = 5;
	localparam int exc_bit_sys   = 8;
	localparam int exc_bit_ri    = 10;
	localparam int exc_bit_cpu   = 11;
	localparam int exc_bit_eret  = 12;   // not its code, eret is reported as 14
	localparam int exc_bit_watch = 23;

	// cp0 register numbers
	localparam logic [4:0] cp0_status_addr = 5'd12;
	localparam logic [4:0] cp0_cause_addr  = 5'd13;
	localparam logic [4:0] cp0_epc_addr    = 5'd14;

endpackage

`default_nettype wire

/* source/mem_stage_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mem_stage_if import mem_pkg::*; ();

	logic             valid;
	mem_op_e          aluop;
	logic [1:0]       byte_off;       // address low bits, picks the load lanes
	logic [4:0]       wd;
	logic             wreg;
	logic [reg_w-1:0] wdata;
	logic [reg_w-1:0] reg2;           // old rt value for lwl/lwr merge
	logic             cp0_we;
	logic [4:0]       cp0_addr;
	logic [reg_w-1:0] cp0_data;
	exc_code_e        exc_code;
	logic [reg_w-1:0] pc;
	logic             in_delayslot;

	modport req (output valid, aluop, byte_off, wd, wreg, wdata, reg2,
		cp0_we, cp0_addr, cp0_data, exc_code, pc, in_delayslot);
	modport fmt (input valid, aluop, byte_off, wd, wreg, wdata, reg2, exc_code, pc);
	modport cp0 (input valid, cp0_we, cp0_addr, cp0_data, exc_code, pc, in_delayslot);

endinterface

`default_nettype wire

/* source/mem_request.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_request import mem_pkg::*; (
	input  logic             clk,
	input  logic             rst_i,
	input  logic             op_valid_i,
	input  mem_op_e          aluop_i,
	input  logic [reg_w-1:0] addr_i,
	input  logic [reg_w-1:0] reg2_i,
	input  logic [4:0]       wd_i,
	input  logic             wreg_i,
	input  logic [reg_w-1:0] wdata_i,
	input  logic             cp0_we_i,
	input  logic [4:0]       cp0_addr_i,
	input  logic [reg_w-1:0] cp0_data_i,
	input  logic [31:0]      except_i,
	input  logic [reg_w-1:0] pc_i,
	input  logic             in_delayslot_i,
	input  logic [reg_w-1:0] status_i,
	input  logic [reg_w-1:0] cause_i,
	output logic             ram_ce_o,
	output logic             ram_we_o,
	output logic [3:0]       ram_sel_o,
	output logic [reg_w-1:0] ram_addr_o,
	output logic [reg_w-1:0] ram_wdata_o,
	mem_stage_if.req         stage
);

	logic             in_valid;
	mem_op_e          in_op;
	logic [reg_w-1:0] in_addr;
	logic [reg_w-1:0] in_reg2;
	logic [4:0]       in_wd;
	logic             in_wreg;
	logic [reg_w-1:0] in_wdata;
	logic             in_cp0_we;
	logic [4:0]       in_cp0_addr;
	logic [reg_w-1:0] in_cp0_data;
	logic [31:0]      in_except;
	logic [reg_w-1:0] in_pc;
	logic             in_ds;
	logic [1:0]       off;
	logic             ce_c;
	logic             we_c;
	logic             adel;
	logic             ades;
	logic [reg_w-1:0] fwd_status;
	logic [reg_w-1:0] fwd_cause;
	logic             int_pending;
	exc_code_e        exc_c;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			in_valid <= 1'b0;
		end else begin
			in_valid <= op_valid_i;
		end
		in_op       <= aluop_i;
		in_addr     <= addr_i;
		in_reg2     <= reg2_i;
		in_wd       <= wd_i;
		in_wreg     <= wreg_i;
		in_wdata    <= wdata_i;
		in_cp0_we   <= cp0_we_i;
		in_cp0_addr <= cp0_addr_i;
		in_cp0_data <= cp0_data_i;
		in_except   <= except_i;
		in_pc       <= pc_i;
		in_ds       <= in_delayslot_i;
	end

	assign off = in_addr[1:0];

	// big-endian lanes with offset 0 in sel[3]
	always_comb begin
		ce_c        = 1'b0;
		we_c        = 1'b0;
		ram_sel_o   = 4'b1111;
		ram_wdata_o = '0;
		adel        = 1'b0;
		ades        = 1'b0;
		case (in_op)
			op_lb, op_lbu: begin
				ce_c      = 1'b1;
				ram_sel_o = 4'b1000 >> off;
			end
			op_lh, op_lhu: begin
				ce_c      = ~off[0];
				ram_sel_o = off[1] ? 4'b0011 : 4'b1100;
				adel      = off[0];
			end
			op_lw: begin
				ce_c = ~|off;
				adel = |off;
			end
			op_lwl, op_lwr: begin
				ce_c = 1'b1;    // full word merged on the way back
			end
			op_sb: begin
				ce_c        = 1'b1;
				we_c        = 1'b1;
				ram_sel_o   = 4'b1000 >> off;
				ram_wdata_o = {4{in_reg2[7:0]}};
			end
			op_sh: begin
				ce_c        = ~off[0];
				we_c        = 1'b1;
				ram_sel_o   = off[0] ? 4'b0000 : (off[1] ? 4'b0011 : 4'b1100);
				ram_wdata_o = {2{in_reg2[15:0]}};
				ades        = off[0];
			end
			op_sw: begin
				ce_c        = ~|off;
				we_c        = 1'b1;
				ram_sel_o   = (|off) ? 4'b0000 : 4'b1111;
				ram_wdata_o = in_reg2;
				ades        = |off;
			end
			op_swl: begin
				ce_c        = 1'b1;
				we_c        = 1'b1;
				ram_sel_o   = 4'b1111 >> off;
				ram_wdata_o = in_reg2 >> {off, 3'b000};    // upper rt bytes from offset down
			end
			op_swr: begin
				ce_c        = 1'b1;
				we_c        = 1'b1;
				ram_sel_o   = 4'b1111 << ~off;
				ram_wdata_o = in_reg2 << {~off, 3'b000};   // lower rt bytes up to offset
			end
			default: begin
				ce_c = 1'b0;
			end
		endcase
	end

	assign ram_ce_o   = ce_c & in_valid;
	assign ram_we_o   = we_c & in_valid & (exc_c == exc_none);
	assign ram_addr_o = {in_addr[reg_w-1:2], 2'b00};

	// previous op is still uncommitted in the stage register
	always_comb begin
		fwd_status = status_i;
		fwd_cause  = cause_i;
		if (stage.valid && stage.exc_code == exc_none && stage.cp0_we) begin
			if (stage.cp0_addr == cp0_status_addr)
				fwd_status = stage.cp0_data;
			if (stage.cp0_addr == cp0_cause_addr) begin
				fwd_cause[9:8]   = stage.cp0_data[9:8];     // soft IP
				fwd_cause[23:22] = stage.cp0_data[23:22];
			end
		end
		if (stage.valid && stage.exc_code == exc_eret)
			fwd_status[1] = 1'b0;
		else if (stage.valid && stage.exc_code != exc_none)
			fwd_status[1] = 1'b1;      // exception entry sets exl
	end

	assign int_pending = (|(fwd_cause[15:8] & fwd_status[15:8])) && !fwd_status[1]
		&& fwd_status[0];

	// fixed priority from interrupt down to eret
	always_comb begin
		exc_c = exc_none;
		if (in_valid) begin
			if (int_pending) exc_c = exc_int;
			else if (in_except[exc_bit_mod]) exc_c = exc_mod;
			else if (in_except[exc_bit_tlbl]) exc_c = exc_tlbl;
			else if (in_except[exc_bit_tlbs]) exc_c = exc_tlbs;
			else if (in_except[exc_bit_adel] || adel) exc_c = exc_adel;
			else if (in_except[exc_bit_ades] || ades) exc_c = exc_ades;
			else if (in_except[exc_bit_sys]) exc_c = exc_sys;
			else if (in_except[exc_bit_ri]) exc_c = exc_ri;
			else if (in_except[exc_bit_cpu]) exc_c = exc_cpu;
			else if (in_except[exc_bit_watch]) exc_c = exc_watch;
			else if (in_except[exc_bit_eret]) exc_c = exc_eret;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			stage.valid <= 1'b0;
		end else begin
			stage.valid <= in_valid;
		end
		stage.aluop        <= in_op;
		stage.byte_off     <= off;
		stage.wd           <= in_wd;
		stage.wreg         <= in_wreg;
		stage.wdata        <= in_wdata;
		stage.reg2         <= in_reg2;
		stage.cp0_we       <= in_cp0_we;
		stage.cp0_addr     <= in_cp0_addr;
		stage.cp0_data     <= in_cp0_data;
		stage.exc_code     <= exc_c;
		stage.pc           <= in_pc;
		stage.in_delayslot <= in_ds;
	end

	// misaligned stores are dropped before they reach the port
	a_write_enabled: assert property (@(posedge clk) disable iff (rst_i)
		ram_we_o |-> ram_ce_o);

endmodule

`default_nettype wire

/* source/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram import mem_pkg::*; (
	input  logic             clk,
	input  logic             ram_ce_i,
	input  logic             ram_we_i,
	input  logic [3:0]       ram_sel_i,
	input  logic [reg_w-1:0] ram_addr_i,
	input  logic [reg_w-1:0] ram_wdata_i,
	output logic [reg_w-1:0] ram_rdata_o
);

	logic [reg_w-1:0]         mem [0:(1 << ram_addr_bits)-1];
	logic [ram_addr_bits-1:0] word;

	assign word = ram_addr_i[ram_addr_bits+1:2];    // byte offset and high bits ignored

	always_ff @(posedge clk) begin
		if (ram_ce_i) begin
			if (ram_we_i) begin
				for (int i = 0; i < 4; i++) begin
					if (ram_sel_i[i])
						mem[word][8*i +: 8] <= ram_wdata_i[8*i +: 8];
				end
			end else begin
				ram_rdata_o <= mem[word];   // whole word, lanes picked downstream
			end
		end
	end

	// the request stage must never issue a write with no lane selected
	a_sel_on_write: assert property (@(posedge clk)
		(ram_ce_i && ram_we_i) |-> (ram_sel_i != 4'b0000));

endmodule

`default_nettype wire

/* source/load_format.sv */
`timescale 1ns/1ps
`default_nettype none

module load_format import mem_pkg::*; (
	input  logic             clk,
	input  logic             rst_i,
	mem_stage_if.fmt         stage,
	input  logic [reg_w-1:0] ram_rdata_i,
	output logic             wb_valid_o,
	output logic [4:0]       wb_wd_o,
	output logic             wb_wreg_o,
	output logic [reg_w-1:0] wb_wdata_o,
	output logic             exc_valid_o,
	output exc_code_e        exc_code_o,
	output logic [reg_w-1:0] exc_pc_o
);

	logic [7:0]       byte_sel;
	logic [15:0]      half_sel;
	logic [reg_w-1:0] result;
	logic             has_exc;

	// offset 0 is the top byte
	assign byte_sel = ram_rdata_i[{~stage.byte_off, 3'b000} +: 8];
	assign half_sel = stage.byte_off[1] ? ram_rdata_i[15:0] : ram_rdata_i[31:16];
	assign has_exc  = (stage.exc_code != exc_none);

	always_comb begin
		case (stage.aluop)
			op_lb:  result = {{24{byte_sel[7]}}, byte_sel};
			op_lbu: result = {24'd0, byte_sel};
			op_lh:  result = {{16{half_sel[15]}}, half_sel};
			op_lhu: result = {16'd0, half_sel};
			op_lw:  result = ram_rdata_i;
			op_lwl: begin
				// memory bytes fill rt from the top
				case (stage.byte_off)
					2'd0:    result = ram_rdata_i;
					2'd1:    result = {ram_rdata_i[23:0], stage.reg2[7:0]};
					2'd2:    result = {ram_rdata_i[15:0], stage.reg2[15:0]};
					default: result = {ram_rdata_i[7:0], stage.reg2[23:0]};
				endcase
			end
			op_lwr: begin
				// memory bytes fill rt from the bottom
				case (stage.byte_off)
					2'd0:    result = {stage.reg2[31:8], ram_rdata_i[31:24]};
					2'd1:    result = {stage.reg2[31:16], ram_rdata_i[31:16]};
					2'd2:    result = {stage.reg2[31:24], ram_rdata_i[31:8]};
					default: result = ram_rdata_i;
				endcase
			end
			default: result = stage.wdata;    // nop and stores pass through
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			wb_valid_o  <= 1'b0;
			exc_valid_o <= 1'b0;
		end else begin
			wb_valid_o  <= stage.valid;
			exc_valid_o <= stage.valid & has_exc;
		end
		wb_wd_o    <= stage.wd;
		wb_wreg_o  <= stage.wreg & ~has_exc;   // excepting op writes no register
		wb_wdata_o <= result;
		exc_code_o <= stage.exc_code;
		exc_pc_o   <= stage.pc;
	end

endmodule

`default_nettype wire

/* source/cp0_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module cp0_regs import mem_pkg::*; (
	input  logic             clk,
	input  logic             rst_i,
	input  logic [5:0]       int_i,
	mem_stage_if.cp0         stage,
	output logic [reg_w-1:0] status_o,
	output logic [reg_w-1:0] cause_o,
	output logic [reg_w-1:0] epc_o
);

	logic commit_ok;
	logic is_eret;

	assign commit_ok = stage.valid && (stage.exc_code == exc_none);
	assign is_eret   = stage.valid && (stage.exc_code == exc_eret);

	always_ff @(posedge clk) begin
		if (rst_i) begin
			status_o <= '0;
			cause_o  <= '0;
			epc_o    <= '0;
		end else begin
			cause_o[15:10] <= int_i;    // hardware IP sampled every cycle

			if (commit_ok && stage.cp0_we) begin
				case (stage.cp0_addr)
					cp0_status_addr: begin
						status_o <= stage.cp0_data;
					end
					cp0_cause_addr: begin
						// only IP[1:0] and bits 22, 23 are writable
						cause_o[9:8]   <= stage.cp0_data[9:8];
						cause_o[23:22] <= stage.cp0_data[23:22];
					end
					cp0_epc_addr: begin
						epc_o <= stage.cp0_data;
					end
					default: ;
				endcase
			end

			if (is_eret) begin
				status_o[1] <= 1'b0;    // leave exception level
			end else if (stage.valid && !commit_ok) begin
				status_o[1]   <= 1'b1;
				cause_o[6:2]  <= stage.exc_code;
				cause_o[31]   <= stage.in_delayslot;   // BD
				// restart at the branch when in a delay slot
				epc_o <= stage.in_delayslot ? stage.pc - 32'd4 : stage.pc;
			end
		end
	end

endmodule

`default_nettype wire

/* source/mem_subsys_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top import mem_pkg::*; (
	input  logic             clk,
	input  logic             rst_i,
	input  logic             op_valid_i,
	input  mem_op_e          aluop_i,
	input  logic [reg_w-1:0] addr_i,
	input  logic [reg_w-1:0] reg2_i,
	input  logic [4:0]       wd_i,
	input  logic             wreg_i,
	input  logic [reg_w-1:0] wdata_i,
	input  logic             cp0_we_i,
	input  logic [4:0]       cp0_addr_i,
	input  logic [reg_w-1:0] cp0_data_i,
	input  logic [31:0]      except_i,
	input  logic [reg_w-1:0] pc_i,
	input  logic             in_delayslot_i,
	input  logic [5:0]       int_i,
	output logic             wb_valid_o,
	output logic [4:0]       wb_wd_o,
	output logic             wb_wreg_o,
	output logic [reg_w-1:0] wb_wdata_o,
	output logic             exc_valid_o,
	output exc_code_e        exc_code_o,
	output logic [reg_w-1:0] exc_pc_o,
	output logic [reg_w-1:0] epc_o
);

	logic             ram_ce;
	logic             ram_we;
	logic [3:0]       ram_sel;
	logic [reg_w-1:0] ram_addr;
	logic [reg_w-1:0] ram_wdata;
	logic [reg_w-1:0] ram_rdata;
	logic [reg_w-1:0] status;
	logic [reg_w-1:0] cause;

	mem_stage_if stage_if ();

	mem_request mem_request_inst (
		.clk(clk), .rst_i(rst_i),
		.op_valid_i(op_valid_i), .aluop_i(aluop_i), .addr_i(addr_i), .reg2_i(reg2_i),
		.wd_i(wd_i), .wreg_i(wreg_i), .wdata_i(wdata_i),
		.cp0_we_i(cp0_we_i), .cp0_addr_i(cp0_addr_i), .cp0_data_i(cp0_data_i),
		.except_i(except_i), .pc_i(pc_i), .in_delayslot_i(in_delayslot_i),
		.status_i(status), .cause_i(cause),
		.ram_ce_o(ram_ce), .ram_we_o(ram_we), .ram_sel_o(ram_sel),
		.ram_addr_o(ram_addr), .ram_wdata_o(ram_wdata),
		.stage(stage_if.req)
	);

	data_ram data_ram_inst (
		.clk(clk), .ram_ce_i(ram_ce), .ram_we_i(ram_we), .ram_sel_i(ram_sel),
		.ram_addr_i(ram_addr), .ram_wdata_i(ram_wdata), .ram_rdata_o(ram_rdata)
	);

	load_format load_format_inst (
		.clk(clk), .rst_i(rst_i), .stage(stage_if.fmt), .ram_rdata_i(ram_rdata),
		.wb_valid_o(wb_valid_o), .wb_wd_o(wb_wd_o), .wb_wreg_o(wb_wreg_o),
		.wb_wdata_o(wb_wdata_o), .exc_valid_o(exc_valid_o), .exc_code_o(exc_code_o),
		.exc_pc_o(exc_pc_o)
	);

	cp0_regs cp0_regs_inst (
		.clk(clk), .rst_i(rst_i), .int_i(int_i), .stage(stage_if.cp0),
		.status_o(status), .cause_o(cause), .epc_o(epc_o)
	);

endmodule

`default_nettype wire

/* verif/mem_ref_model.svh */
// reference model for the memory stage, included into the testbench module
// works on the testbench drive signals, so it is included after they are declared

typedef struct packed {
	logic [4:0]  wd;
	logic        wreg;
	logic [31:0] wdata;
	exc_code_e   code;
	logic [31:0] pc;
	logic [31:0] epc;
} wb_entry_t;

logic [31:0] ram_mirror [0:255];
logic [31:0] m_status = '0;
logic [31:0] m_cause  = '0;
logic [31:0] m_epc    = '0;
wb_entry_t   exp_q [$];

// big-endian: byte offset 0 is bits 31..24
function automatic logic [31:0] load_result(mem_op_e op, logic [1:0] off,
		logic [31:0] w, logic [31:0] r);
	logic [7:0]  b;
	logic [15:0] h;
	int          sh;
	sh = 8 * int'(off);
	b  = 8'(w >> (24 - sh));
	h  = off[1] ? w[15:0] : w[31:16];
	case (op)
		op_lb:   return {{24{b[7]}}, b};
		op_lbu:  return {24'd0, b};
		op_lh:   return {{16{h[15]}}, h};
		op_lhu:  return {16'd0, h};
		op_lwl:  return (w << sh) | (r & ~(32'hffff_ffff << sh));   // keep low rt bytes
		op_lwr:  return (w >> (24 - sh)) | (r & ~(32'hffff_ffff >> (24 - sh)));
		default: return w;
	endcase
endfunction

function automatic logic [31:0] store_merge(mem_op_e op, logic [1:0] off,
		logic [31:0] old, logic [31:0] r);
	logic [31:0] mask;
	logic [31:0] data;
	int          sh;
	sh   = 8 * int'(off);
	mask = '0;
	data = '0;
	case (op)
		op_sb: begin
			mask = 32'hff00_0000 >> sh;
			data = {4{r[7:0]}};
		end
		op_sh: begin
			mask = off[1] ? 32'h0000_ffff : 32'hffff_0000;
			data = {2{r[15:0]}};
		end
		op_sw: begin
			mask = 32'hffff_ffff;
			data = r;
		end
		op_swl: begin
			mask = 32'hffff_ffff >> sh;    // offset down to the low end
			data = r >> sh;
		end
		op_swr: begin
			mask = 32'hffff_ffff << (24 - sh);
			data = r << (24 - sh);
		end
		default: begin
			mask = '0;
		end
	endcase
	return (old & ~mask) | (data & mask);
endfunction

function automatic exc_code_e pick_exception(mem_op_e op, logic [1:0] off,
		logic [31:0] x, logic int_hit);
	logic      mis_load;
	logic      mis_store;
	exc_code_e c;
	mis_load  = ((op == op_lh || op == op_lhu) && off[0]) || (op == op_lw && off != 2'b00);
	mis_store = (op == op_sh && off[0]) || (op == op_sw && off != 2'b00);
	c = exc_none;
	if (int_hit) c = exc_int;
	else if (x[exc_bit_mod]) c = exc_mod;
	else if (x[exc_bit_tlbl]) c = exc_tlbl;
	else if (x[exc_bit_tlbs]) c = exc_tlbs;
	else if (x[exc_bit_adel] || mis_load) c = exc_adel;
	else if (x[exc_bit_ades] || mis_store) c = exc_ades;
	else if (x[exc_bit_sys]) c = exc_sys;
	else if (x[exc_bit_ri]) c = exc_ri;
	else if (x[exc_bit_cpu]) c = exc_cpu;
	else if (x[exc_bit_watch]) c = exc_watch;
	else if (x[exc_bit_eret]) c = exc_eret;
	return c;
endfunction

// executes the op now on the drive signals, in program order
task automatic issue_to_model();
	wb_entry_t  e;
	logic [1:0] off;
	logic [7:0] word;
	logic       int_hit;
	off  = addr_i[1:0];
	word = addr_i[9:2];
	m_cause[15:10] = int_i;    // hardware lines are sampled as the op registers
	int_hit = (|(m_cause[15:8] & m_status[15:8])) && !m_status[1] && m_status[0];
	e.code  = pick_exception(aluop_i, off, except_i, int_hit);
	e.wd    = wd_i;
	e.wreg  = wreg_i && (e.code == exc_none);
	e.wdata = wdata_i;
	e.pc    = pc_i;
	if (e.code == exc_none) begin
		if (aluop_i >= op_lb && aluop_i <= op_lwr)
			e.wdata = load_result(aluop_i, off, ram_mirror[word], reg2_i);
		else if (aluop_i >= op_sb)
			ram_mirror[word] = store_merge(aluop_i, off, ram_mirror[word], reg2_i);
		if (cp0_we_i && cp0_addr_i == cp0_status_addr) begin
			m_status = cp0_data_i;
		end else if (cp0_we_i && cp0_addr_i == cp0_cause_addr) begin
			m_cause[9:8]   = cp0_data_i[9:8];
			m_cause[23:22] = cp0_data_i[23:22];
		end else if (cp0_we_i && cp0_addr_i == cp0_epc_addr) begin
			m_epc = cp0_data_i;
		end
	end else if (e.code == exc_eret) begin
		m_status[1] = 1'b0;
	end else begin
		m_status[1]  = 1'b1;
		m_cause[6:2] = e.code;
		m_cause[31]  = in_delayslot_i;
		m_epc        = in_delayslot_i ? pc_i - 32'd4 : pc_i;
	end
	e.epc = m_epc;
	exp_q.push_back(e);
endtask

/* verif/mem_subsys_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_tb import mem_pkg::*; ();

	localparam int          n_ops        = 2000;
	localparam int          window_words = 16;
	localparam logic [31:0] window_base  = 32'h0000_0080;   // ram words 32..47
	localparam logic [31:0] exc_mask     = 32'h0080_1d3e;   // all defined except_i flags

	logic             clk = 1'b0;
	logic             rst_i;
	logic             op_valid_i;
	mem_op_e          aluop_i;
	logic [31:0]      addr_i;
	logic [31:0]      reg2_i;
	logic [4:0]       wd_i;
	logic             wreg_i;
	logic [31:0]      wdata_i;
	logic             cp0_we_i;
	logic [4:0]       cp0_addr_i;
	logic [31:0]      cp0_data_i;
	logic [31:0]      except_i;
	logic [31:0]      pc_i;
	logic             in_delayslot_i;
	logic [5:0]       int_i;
	logic             wb_valid_o;
	logic [4:0]       wb_wd_o;
	logic             wb_wreg_o;
	logic [31:0]      wb_wdata_o;
	logic             exc_valid_o;
	exc_code_e        exc_code_o;
	logic [31:0]      exc_pc_o;
	logic [31:0]      epc_o;
	int               n_out = 0;

	`include "mem_ref_model.svh"

	mem_subsys_top mem_subsys_top_inst (.*);

	always #2 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("TEST FAIL");
			$fatal(1, "first mismatch, run stopped");
		end
	endtask

	task automatic compare_outputs();
		wb_entry_t e;
		if (wb_valid_o) begin
			if (exp_q.size() == 0) begin
				$display("writeback seen at %0t with no operation outstanding", $time);
				$display("TEST FAIL");
				$fatal(1, "unexpected writeback");
			end else begin
				e = exp_q.pop_front();
				n_out++;
				check_value("wb_wd", 32'(wb_wd_o), 32'(e.wd));
				check_value("wb_wreg", 32'(wb_wreg_o), 32'(e.wreg));
				if (e.wreg)
					check_value("wb_wdata", wb_wdata_o, e.wdata);
				check_value("exc_valid", 32'(exc_valid_o), 32'(e.code != exc_none));
				check_value("exc_code", 32'(exc_code_o), 32'(e.code));
				if (e.code != exc_none)
					check_value("exc_pc", exc_pc_o, e.pc);
				check_value("epc", epc_o, e.epc);
			end
		end
	endtask

	task automatic idle_inputs();
		op_valid_i     = 1'b0;
		aluop_i        = op_nop;
		addr_i         = '0;
		reg2_i         = '0;
		wd_i           = '0;
		wreg_i         = 1'b0;
		wdata_i        = '0;
		cp0_we_i       = 1'b0;
		cp0_addr_i     = '0;
		cp0_data_i     = '0;
		except_i       = '0;
		pc_i           = '0;
		in_delayslot_i = 1'b0;
		int_i          = '0;
	endtask

	// aligned sw so every window word holds known data before loads start
	task automatic drive_fill_store(input int idx);
		idle_inputs();
		op_valid_i = 1'b1;
		aluop_i    = op_sw;
		addr_i     = window_base + 32'(idx * 4);
		reg2_i     = $urandom;
		issue_to_model();
	endtask

	task automatic drive_random_op();
		int unsigned kind;
		logic [31:0] off;
		idle_inputs();
		kind           = $urandom % 100;
		off            = ($urandom % 2 == 0) ? 32'd0 : $urandom % 4;   // lean to aligned
		op_valid_i     = 1'b1;
		addr_i         = window_base + (($urandom % window_words) << 2) + off;
		reg2_i         = $urandom;
		wd_i           = 5'($urandom);
		wdata_i        = $urandom;
		wreg_i         = 1'($urandom);
		pc_i           = $urandom & 32'hffff_fffc;
		in_delayslot_i = 1'($urandom);
		int_i          = ($urandom % 4 == 0) ? 6'($urandom) : 6'd0;
		if ($urandom % 8 == 0)
			except_i = $urandom & $urandom & exc_mask;   // sparse and often several at once
		if (kind < 40) begin
			aluop_i = mem_op_e'(4'(32'd1 + $urandom % 7));   // lb .. lwr
			wreg_i  = 1'b1;
		end else if (kind < 75) begin
			aluop_i = mem_op_e'(4'(32'd8 + $urandom % 5));   // sb .. swr
		end else if (kind < 88) begin
			cp0_we_i   = 1'b1;    // mtc0 carried on a nop
			cp0_addr_i = 5'(32'd12 + $urandom % 3);
			cp0_data_i = (cp0_addr_i == cp0_status_addr) ?
				(($urandom & 32'h0000_ff00) | 32'h1) : $urandom;
		end else if (kind < 94) begin
			except_i = 32'h1 << exc_bit_eret;
		end
		issue_to_model();
	endtask

	initial begin
		void'($urandom(32'h445c));
		idle_inputs();
		rst_i = 1'b1;
		repeat (3) @(posedge clk);
		#0.5;
		rst_i = 1'b0;
		for (int i = 0; i < n_ops; i++) begin
			if (i < window_words)
				drive_fill_store(i);
			else
				drive_random_op();
			@(posedge clk);
			#0.5;
			compare_outputs();
		end
		idle_inputs();
		// the last two ops are still in the two-cycle pipe
		repeat (2) begin
			@(posedge clk);
			#0.5;
			compare_outputs();
		end
		@(posedge clk);
		#0.5;
		compare_outputs();    // nothing should trail the last op
		if (n_out == n_ops && exp_q.size() == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			$display("saw %0d writebacks for %0d operations", n_out, n_ops);
			$display("TEST FAIL");
			$fatal(1, "writeback count wrong");
		end
	end

	// watchdog
	initial begin
		#((n_ops + 20) * 4);
		$display("timeout: writebacks did not all arrive in time");
		$display("TEST FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+verif
source/mem_pkg.sv
source/mem_stage_if.sv
source/mem_request.sv
source/data_ram.sv
source/load_format.sv
source/cp0_regs.sv
source/mem_subsys_top.sv
verif/mem_subsys_tb.sv

/* run.sh */
#!/bin/sh
# build and run the memory stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f compile.f --top-module mem_subsys_tb -Mdir obj_dir -o mem_subsys_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/mem_subsys_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

echo "simulation finished cleanly"
exit 0
